/* src/alu_defs.svh */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// datapath and register file widths
`define ALU_DATA_W 32
`define ALU_REG_W 4
`define ALU_MODE_W 3
`define ALU_OP2_W 12

// writing this register with S set may restore from SPSR
`define ALU_PC_REG 4'd15

`endif

/* src/alu_isa_pkg.sv */
`default_nettype none

`include "alu_defs.svh"

package alu_isa_pkg;

    // only the data-processing opcodes handled here
    typedef enum logic [3:0] {
        AND = 4'd0,
        ADD = 4'd4,
        CMP = 4'd10,
        MOV = 4'd13
    } opcode_e;

    // operand2 is either a plain immediate or a shifted register
    typedef union packed {
        logic [`ALU_OP2_W-1:0] imm;
        struct packed {
            logic [`ALU_OP2_W-`ALU_REG_W-1:0] shift;
            logic [`ALU_REG_W-1:0] rm;
        } reg_form;
    } operand2_u;

    typedef struct packed {
        logic immediate;
        opcode_e opcode;
        logic s;
        logic [`ALU_REG_W-1:0] rn;
        logic [`ALU_REG_W-1:0] rd;
        operand2_u operand2;
    } instr_t;

endpackage

`default_nettype wire

/* src/alu_psr_pkg.sv */
`default_nettype none

`include "alu_defs.svh"

package alu_psr_pkg;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // condition flags sit in the top nibble
    typedef struct packed {
        flags_t flags;
        logic [`ALU_DATA_W-5:0] rest;
    } psr_t;

    typedef logic [`ALU_MODE_W-1:0] mode_t;

endpackage

`default_nettype wire

/* src/alu_ifs.sv */
`default_nettype none

`include "alu_defs.svh"

// operands in, result and adder flags out
interface exec_if;
    logic [`ALU_DATA_W-1:0] op1;
    logic [`ALU_DATA_W-1:0] op2;
    alu_isa_pkg::opcode_e opcode;
    logic [`ALU_DATA_W-1:0] result;
    logic carry;
    logic overflow;

    modport seq (output opcode, input result);
    modport fetch (output op1, op2);
    modport dp (input op1, op2, opcode, output result, carry, overflow);
    modport psr (input result, carry, overflow);
endinterface

// handshake between sequencer and status-register unit
interface psr_if;
    logic start;
    logic update;
    alu_psr_pkg::flags_t flags_in;
    alu_psr_pkg::psr_t old_cpsr;
    alu_psr_pkg::mode_t mode;
    logic done;
    logic restore;

    modport seq (output start, update, input done, restore);
    modport unit (input start, update, output flags_in, old_cpsr, mode, done, restore);
endinterface

`default_nettype wire

/* src/alu_datapath.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_datapath (
    exec_if.dp                       ex,
    input wire alu_psr_pkg::flags_t  old_flags
);

    localparam int MSB = `ALU_DATA_W - 1;

    logic [`ALU_DATA_W:0] sum;
    logic [`ALU_DATA_W:0] diff;

    assign sum = {1'b0, ex.op1} + {1'b0, ex.op2};
    assign diff = {1'b0, ex.op1} - {1'b0, ex.op2};

    always_comb begin
        // logical ops leave C and V as they were
        ex.result = '0;
        ex.carry = old_flags.c;
        ex.overflow = old_flags.v;
        case (ex.opcode)
            alu_isa_pkg::ADD: begin
                ex.result = sum[MSB:0];
                ex.carry = sum[`ALU_DATA_W];
                ex.overflow = ~(ex.op1[MSB] ^ ex.op2[MSB]) & (ex.op1[MSB] ^ sum[MSB]);
            end
            alu_isa_pkg::CMP: begin
                ex.result = diff[MSB:0];
                // carry is not-borrow
                ex.carry = ~diff[`ALU_DATA_W];
                ex.overflow = (ex.op1[MSB] ^ ex.op2[MSB]) & (ex.op1[MSB] ^ diff[MSB]);
            end
            alu_isa_pkg::AND: ex.result = ex.op1 & ex.op2;
            alu_isa_pkg::MOV: ex.result = ex.op2;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/operand_fetch.sv */
`default_nettype none

`include "alu_defs.svh"

module operand_fetch (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire alu_isa_pkg::instr_t    instr,
    input  wire logic                   fetch_go,
    output logic                        fetch_done,
    output logic                        read_en,
    output logic [`ALU_REG_W-1:0]       read_reg,
    input  wire logic [`ALU_DATA_W-1:0] read_value,
    exec_if.fetch                       ex
);

    typedef enum logic [2:0] {
        F_IDLE, F_OP1_WAIT, F_OP1_TAKE, F_OP2, F_OP2_WAIT, F_OP2_TAKE
    } fetch_state_e;

    fetch_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= F_IDLE;
            read_en <= 1'b0;
            read_reg <= '0;
            fetch_done <= 1'b0;
        end else begin
            read_en <= 1'b0;
            fetch_done <= 1'b0;
            case (state)
                F_IDLE: begin
                    if (fetch_go) begin
                        // MOV has no first operand
                        if (instr.opcode == alu_isa_pkg::MOV) begin
                            state <= F_OP2;
                        end else begin
                            read_en <= 1'b1;
                            read_reg <= instr.rn;
                            state <= F_OP1_WAIT;
                        end
                    end
                end
                F_OP1_WAIT: state <= F_OP1_TAKE;
                F_OP1_TAKE: state <= F_OP2;
                F_OP2: begin
                    if (instr.immediate) begin
                        fetch_done <= 1'b1;
                        state <= F_IDLE;
                    end else begin
                        read_en <= 1'b1;
                        read_reg <= instr.operand2.reg_form.rm;
                        state <= F_OP2_WAIT;
                    end
                end
                F_OP2_WAIT: state <= F_OP2_TAKE;
                F_OP2_TAKE: begin
                    fetch_done <= 1'b1;
                    state <= F_IDLE;
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            F_IDLE: begin
                if (fetch_go && instr.opcode == alu_isa_pkg::MOV) begin
                    ex.op1 <= '0;
                end
            end
            F_OP1_TAKE: ex.op1 <= read_value;
            F_OP2: begin
                // no rotation on the immediate form
                if (instr.immediate) begin
                    ex.op2 <= {{(`ALU_DATA_W-`ALU_OP2_W){1'b0}}, instr.operand2.imm};
                end
            end
            F_OP2_TAKE: ex.op2 <= read_value;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/psr_unit.sv */
`default_nettype none

`include "alu_defs.svh"

module psr_unit (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`ALU_REG_W-1:0]  rd,
    input  wire logic                   s,
    output logic                        mode_read_en,
    input  wire logic [`ALU_DATA_W-1:0] mode_read_value,
    output logic                        cpsr_read_en,
    input  wire logic [`ALU_DATA_W-1:0] cpsr_read_value,
    output logic                        cpsr_write_en,
    output logic [`ALU_DATA_W-1:0]      cpsr_write_value,
    psr_if.unit                         psr,
    exec_if.psr                         ex
);

    typedef enum logic [2:0] {
        P_IDLE, P_MODE_WAIT, P_MODE_TAKE, P_CPSR_REQ, P_CPSR_WAIT, P_CPSR_TAKE, P_WRITE
    } psr_state_e;

    psr_state_e state;
    alu_psr_pkg::psr_t new_psr;

    // user and FIQ-less low modes have no SPSR
    assign psr.restore = (rd == `ALU_PC_REG) && s && (psr.mode > alu_psr_pkg::mode_t'(1));
    assign psr.flags_in = psr.old_cpsr.flags;

    always_comb begin
        new_psr = psr.old_cpsr;
        new_psr.flags.n = ex.result[`ALU_DATA_W-1];
        new_psr.flags.z = (ex.result == '0);
        new_psr.flags.c = ex.carry;
        new_psr.flags.v = ex.overflow;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= P_IDLE;
            mode_read_en <= 1'b0;
            cpsr_read_en <= 1'b0;
            cpsr_write_en <= 1'b0;
            psr.done <= 1'b0;
        end else begin
            mode_read_en <= 1'b0;
            cpsr_read_en <= 1'b0;
            cpsr_write_en <= 1'b0;
            psr.done <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (psr.start) begin
                        mode_read_en <= 1'b1;
                        state <= P_MODE_WAIT;
                    end else if (psr.update) begin
                        cpsr_write_en <= 1'b1;
                        state <= P_WRITE;
                    end
                end
                P_MODE_WAIT: state <= P_MODE_TAKE;
                P_MODE_TAKE: state <= P_CPSR_REQ;
                P_CPSR_REQ: begin
                    cpsr_read_en <= 1'b1;
                    state <= P_CPSR_WAIT;
                end
                P_CPSR_WAIT: state <= P_CPSR_TAKE;
                P_CPSR_TAKE: begin
                    psr.done <= 1'b1;
                    state <= P_IDLE;
                end
                P_WRITE: begin
                    psr.done <= 1'b1;
                    state <= P_IDLE;
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == P_MODE_TAKE) begin
            psr.mode <= mode_read_value[`ALU_MODE_W-1:0];
        end
        if (state == P_CPSR_TAKE) begin
            psr.old_cpsr <= cpsr_read_value;
        end
        if (state == P_IDLE && psr.update && !psr.start) begin
            cpsr_write_value <= new_psr;
        end
    end

endmodule

`default_nettype wire

/* src/alu_sequencer.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_sequencer (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   en,
    input  wire logic                   immediate,
    input  wire logic [3:0]             opcode,
    input  wire logic                   s,
    input  wire logic [`ALU_REG_W-1:0]  rn,
    input  wire logic [`ALU_REG_W-1:0]  rd,
    input  wire logic [`ALU_OP2_W-1:0]  operand2,
    output logic                        busy,
    output logic                        write_en,
    output logic [`ALU_REG_W-1:0]       write_reg,
    output logic [`ALU_DATA_W-1:0]      write_value,
    output logic                        write_restore_from_spsr,
    output alu_isa_pkg::instr_t         instr,
    output logic                        fetch_go,
    input  wire logic                   fetch_done,
    exec_if.seq                         ex,
    psr_if.seq                          psr
);

    typedef enum logic [2:0] {S_IDLE, S_PSR, S_FETCH, S_WRITE, S_FLAGS} seq_state_e;

    seq_state_e state;
    logic wr_op;
    logic flag_op;

    // unknown opcodes fall through with no write at all
    assign wr_op = instr.opcode inside {alu_isa_pkg::AND, alu_isa_pkg::ADD, alu_isa_pkg::MOV};
    assign flag_op = (instr.opcode == alu_isa_pkg::CMP) || (wr_op && instr.s);

    assign busy = (state != S_IDLE);
    assign ex.opcode = instr.opcode;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            psr.start <= 1'b0;
            psr.update <= 1'b0;
            fetch_go <= 1'b0;
            write_en <= 1'b0;
        end else begin
            psr.start <= 1'b0;
            psr.update <= 1'b0;
            fetch_go <= 1'b0;
            write_en <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (en) begin
                        psr.start <= 1'b1;
                        state <= S_PSR;
                    end
                end
                S_PSR: begin
                    if (psr.done) begin
                        fetch_go <= 1'b1;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (fetch_done) begin
                        write_en <= wr_op;
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    psr.update <= flag_op;
                    state <= flag_op ? S_FLAGS : S_IDLE;
                end
                S_FLAGS: begin
                    if (psr.done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && en) begin
            instr.immediate <= immediate;
            instr.opcode <= alu_isa_pkg::opcode_e'(opcode);
            instr.s <= s;
            instr.rn <= rn;
            instr.rd <= rd;
            instr.operand2 <= operand2;
        end
        // operands are settled by the time fetch_done is seen
        if (state == S_FETCH && fetch_done) begin
            write_reg <= instr.rd;
            write_value <= ex.result;
            write_restore_from_spsr <= psr.restore;
        end
    end

endmodule

`default_nettype wire

/* src/alu_top.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   en,
    input  wire logic                   immediate,
    input  wire logic [3:0]             opcode,
    input  wire logic                   s,
    input  wire logic [`ALU_REG_W-1:0]  rn,
    input  wire logic [`ALU_REG_W-1:0]  rd,
    input  wire logic [`ALU_OP2_W-1:0]  operand2,
    output logic                        write_restore_from_spsr,
    output logic                        write_en,
    output logic [`ALU_REG_W-1:0]       write_reg,
    output logic [`ALU_DATA_W-1:0]      write_value,
    output logic                        read_en,
    output logic [`ALU_REG_W-1:0]       read_reg,
    input  wire logic [`ALU_DATA_W-1:0] read_value,
    output logic                        mode_read_en,
    input  wire logic [`ALU_DATA_W-1:0] mode_read_value,
    output logic                        cpsr_read_en,
    input  wire logic [`ALU_DATA_W-1:0] cpsr_read_value,
    output logic                        cpsr_write_en,
    output logic [`ALU_DATA_W-1:0]      cpsr_write_value,
    output logic                        busy
);

    alu_isa_pkg::instr_t instr;
    logic fetch_go;
    logic fetch_done;

    exec_if ex_bus ();
    psr_if psr_bus ();

    alu_sequencer i_sequencer (
        .clk(clk), .rst_n(rst_n), .en(en), .immediate(immediate), .opcode(opcode),
        .s(s), .rn(rn), .rd(rd), .operand2(operand2), .busy(busy),
        .write_en(write_en), .write_reg(write_reg), .write_value(write_value),
        .write_restore_from_spsr(write_restore_from_spsr), .instr(instr),
        .fetch_go(fetch_go), .fetch_done(fetch_done), .ex(ex_bus.seq), .psr(psr_bus.seq)
    );

    operand_fetch i_operand_fetch (
        .clk(clk), .rst_n(rst_n), .instr(instr), .fetch_go(fetch_go),
        .fetch_done(fetch_done), .read_en(read_en), .read_reg(read_reg),
        .read_value(read_value), .ex(ex_bus.fetch)
    );

    psr_unit i_psr_unit (
        .clk(clk), .rst_n(rst_n), .rd(instr.rd), .s(instr.s),
        .mode_read_en(mode_read_en), .mode_read_value(mode_read_value),
        .cpsr_read_en(cpsr_read_en), .cpsr_read_value(cpsr_read_value),
        .cpsr_write_en(cpsr_write_en), .cpsr_write_value(cpsr_write_value),
        .psr(psr_bus.unit), .ex(ex_bus.psr)
    );

    // old C and V reach the datapath straight from the status unit
    alu_datapath i_datapath (
        .ex(ex_bus.dp), .old_flags(psr_bus.flags_in)
    );

endmodule

`default_nettype wire

/* bench/alu_chk.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_chk (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic                busy,
    input wire logic                read_en,
    input wire logic                mode_read_en,
    input wire logic                cpsr_read_en,
    input wire logic                write_en,
    input wire logic                cpsr_write_en,
    input wire alu_isa_pkg::instr_t instr
);

    int fails = 0;

    // every strobe is a single-cycle pulse
    a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_en |=> !read_en)
        else begin
            fails++;
            $error("read_en high for more than one cycle");
        end

    a_mode_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                   mode_read_en |=> !mode_read_en)
        else begin
            fails++;
            $error("mode_read_en high for more than one cycle");
        end

    a_cpsr_read_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                        cpsr_read_en |=> !cpsr_read_en)
        else begin
            fails++;
            $error("cpsr_read_en high for more than one cycle");
        end

    a_write_pulse: assert property (@(posedge clk) disable iff (!rst_n) write_en |=> !write_en)
        else begin
            fails++;
            $error("write_en high for more than one cycle");
        end

    a_cpsr_write_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                         cpsr_write_en |=> !cpsr_write_en)
        else begin
            fails++;
            $error("cpsr_write_en high for more than one cycle");
        end

    // compare only touches the flags
    a_no_cmp_write: assert property (@(posedge clk) disable iff (!rst_n)
                                     write_en |-> instr.opcode != alu_isa_pkg::CMP)
        else begin
            fails++;
            $error("register write during a CMP");
        end

    a_read_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
                                       (read_en || mode_read_en || cpsr_read_en) |-> busy)
        else begin
            fails++;
            $error("read strobe while the unit is idle");
        end

endmodule

bind alu_top alu_chk i_chk (
    .clk(clk),
    .rst_n(rst_n),
    .busy(busy),
    .read_en(read_en),
    .mode_read_en(mode_read_en),
    .cpsr_read_en(cpsr_read_en),
    .write_en(write_en),
    .cpsr_write_en(cpsr_write_en),
    .instr(instr)
);

`default_nettype wire

/* bench/alu_tb.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_tb;

    localparam int MAX_TESTS = 32;
    localparam int COLS = 15;
    localparam int CYCLES_PER_TEST = 200;

    typedef struct {
        logic                   immediate;
        logic [3:0]             opcode;
        logic                   s;
        logic [`ALU_REG_W-1:0]  rn;
        logic [`ALU_REG_W-1:0]  rd;
        logic [`ALU_OP2_W-1:0]  operand2;
        logic [`ALU_DATA_W-1:0] rn_value;
        logic [`ALU_DATA_W-1:0] rm_value;
        alu_psr_pkg::mode_t     mode;
        alu_psr_pkg::psr_t      cpsr;
        logic [`ALU_DATA_W-1:0] exp_value;
        logic                   exp_wr;
        logic                   exp_restore;
        logic                   exp_cw;
        alu_psr_pkg::psr_t      exp_cpsr;
    } test_t;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic en = 1'b0;
    logic immediate = 1'b0;
    logic [3:0] opcode = 4'd0;
    logic s = 1'b0;
    logic [`ALU_REG_W-1:0] rn = '0;
    logic [`ALU_REG_W-1:0] rd = '0;
    logic [`ALU_OP2_W-1:0] operand2 = '0;
    logic [`ALU_DATA_W-1:0] read_value = '0;
    logic [`ALU_DATA_W-1:0] mode_read_value = '0;
    logic [`ALU_DATA_W-1:0] cpsr_read_value = '0;

    logic write_restore_from_spsr;
    logic write_en;
    logic [`ALU_REG_W-1:0] write_reg;
    logic [`ALU_DATA_W-1:0] write_value;
    logic read_en;
    logic [`ALU_REG_W-1:0] read_reg;
    logic mode_read_en;
    logic cpsr_read_en;
    logic cpsr_write_en;
    logic [`ALU_DATA_W-1:0] cpsr_write_value;
    logic busy;

    logic [`ALU_DATA_W-1:0] test_words [0:MAX_TESTS*COLS];
    test_t cur;
    int cur_num;
    int num_tests;
    bit loaded = 1'b0;

    // filled by the write monitor
    int wr_count = 0;
    int cpsr_wr_count = 0;
    logic [`ALU_DATA_W-1:0] got_value;
    logic [`ALU_REG_W-1:0] got_reg;
    logic got_restore;
    alu_psr_pkg::psr_t got_cpsr;

    int data_errs = 0;
    int reg_errs = 0;
    int bit_errs = 0;
    int psr_errs = 0;
    int count_errs = 0;
    int mov_rn_reads = 0;

    always #2 clk = ~clk;

    alu_top i_alu_top (
        .clk(clk),
        .rst_n(rst_n),
        .en(en),
        .immediate(immediate),
        .opcode(opcode),
        .s(s),
        .rn(rn),
        .rd(rd),
        .operand2(operand2),
        .write_restore_from_spsr(write_restore_from_spsr),
        .write_en(write_en),
        .write_reg(write_reg),
        .write_value(write_value),
        .read_en(read_en),
        .read_reg(read_reg),
        .read_value(read_value),
        .mode_read_en(mode_read_en),
        .mode_read_value(mode_read_value),
        .cpsr_read_en(cpsr_read_en),
        .cpsr_read_value(cpsr_read_value),
        .cpsr_write_en(cpsr_write_en),
        .cpsr_write_value(cpsr_write_value),
        .busy(busy)
    );

    // register, mode and cpsr responders, data ready before the second edge
    always @(posedge clk) begin
        if (read_en) begin
            if (cur.opcode == alu_isa_pkg::MOV && read_reg == cur.rn) begin
                $display("t=%0t test %0d: rn was read during a MOV", $time, cur_num);
                mov_rn_reads++;
            end
            read_value <= (read_reg == cur.rn) ? cur.rn_value : cur.rm_value;
        end
        if (mode_read_en) begin
            mode_read_value <= {{(`ALU_DATA_W-`ALU_MODE_W){1'b0}}, cur.mode};
        end
        if (cpsr_read_en) begin
            cpsr_read_value <= cur.cpsr;
        end
    end

    always @(posedge clk) begin
        if (write_en) begin
            wr_count++;
            got_value = write_value;
            got_reg = write_reg;
            got_restore = write_restore_from_spsr;
        end
        if (cpsr_write_en) begin
            cpsr_wr_count++;
            got_cpsr = cpsr_write_value;
        end
    end

    task automatic check_data(string name, logic [`ALU_DATA_W-1:0] got,
                              logic [`ALU_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t test %0d %s got %h expected %h", $time, cur_num, name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_reg(string name, logic [`ALU_REG_W-1:0] got,
                             logic [`ALU_REG_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t test %0d %s got %0d expected %0d", $time, cur_num, name, got, exp);
            reg_errs++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t test %0d %s got %b expected %b", $time, cur_num, name, got, exp);
            bit_errs++;
        end
    endtask

    task automatic check_psr(string name, alu_psr_pkg::psr_t got, alu_psr_pkg::psr_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t test %0d %s got %h (nzcv %b) expected %h (nzcv %b)",
                     $time, cur_num, name, got, got.flags, exp, exp.flags);
            psr_errs++;
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("FAIL t=%0t test %0d %s got %0d expected %0d", $time, cur_num, name, got, exp);
            count_errs++;
        end
    endtask

    // the list ends at a line whose first word is all ones
    function automatic int count_tests();
        for (int i = 0; i < MAX_TESTS; i++) begin
            if (test_words[i*COLS] == 32'hffff_ffff) begin
                return i;
            end
        end
        return 0;
    endfunction

    task automatic load_test(int idx);
        int base;
        base = idx * COLS;
        cur.immediate = test_words[base][0];
        cur.opcode = test_words[base+1][3:0];
        cur.s = test_words[base+2][0];
        cur.rn = test_words[base+3][`ALU_REG_W-1:0];
        cur.rd = test_words[base+4][`ALU_REG_W-1:0];
        cur.operand2 = test_words[base+5][`ALU_OP2_W-1:0];
        cur.rn_value = test_words[base+6];
        cur.rm_value = test_words[base+7];
        cur.mode = test_words[base+8][`ALU_MODE_W-1:0];
        cur.cpsr = test_words[base+9];
        cur.exp_value = test_words[base+10];
        cur.exp_wr = test_words[base+11][0];
        cur.exp_restore = test_words[base+12][0];
        cur.exp_cw = test_words[base+13][0];
        cur.exp_cpsr = test_words[base+14];
    endtask

    task automatic run_test();
        int wr_start;
        int cw_start;
        wr_start = wr_count;
        cw_start = cpsr_wr_count;
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
        en <= 1'b1;
        immediate <= cur.immediate;
        opcode <= cur.opcode;
        s <= cur.s;
        rn <= cur.rn;
        rd <= cur.rd;
        operand2 <= cur.operand2;
        @(posedge clk);
        en <= 1'b0;
        // fields change once accepted, only the stored copy is valid now
        immediate <= ~cur.immediate;
        opcode <= ~cur.opcode;
        s <= ~cur.s;
        rn <= ~cur.rn;
        rd <= ~cur.rd;
        operand2 <= ~cur.operand2;
        // busy shows up one edge after acceptance
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
        check_count("write_en pulses", wr_count - wr_start, cur.exp_wr ? 1 : 0);
        if (cur.exp_wr) begin
            check_data("write_value", got_value, cur.exp_value);
            check_reg("write_reg", got_reg, cur.rd);
            check_bit("write_restore_from_spsr", got_restore, cur.exp_restore);
        end
        check_count("cpsr_write_en pulses", cpsr_wr_count - cw_start, cur.exp_cw ? 1 : 0);
        if (cur.exp_cw) begin
            check_psr("cpsr_write_value", got_cpsr, cur.exp_cpsr);
        end
    endtask

    initial begin
        int total;
        $readmemh("bench/alu_tests.txt", test_words);
        num_tests = count_tests();
        if (num_tests == 0) begin
            $display("no tests found in bench/alu_tests.txt, or its end marker is missing");
            $display("** FAIL **");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (5) @(posedge clk);
            rst_n <= 1'b1;
            for (int i = 0; i < num_tests; i++) begin
                cur_num = i;
                load_test(i);
                run_test();
            end
            @(posedge clk);
            total = data_errs + reg_errs + bit_errs + psr_errs + count_errs + mov_rn_reads
                    + i_alu_top.i_chk.fails;
            $display("tests %0d, errors %0d: data %0d reg %0d bit %0d psr %0d count %0d read %0d assert %0d",
                     num_tests, total, data_errs, reg_errs, bit_errs, psr_errs, count_errs,
                     mov_rn_reads, i_alu_top.i_chk.fails);
            if (total == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (CYCLES_PER_TEST * num_tests + 10) @(posedge clk);
        $display("timeout: %0d tests did not finish within %0d cycles",
                 num_tests, CYCLES_PER_TEST * num_tests + 10);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/alu_tests.txt */
// imm opc s rn rd op2 | rn_value rm_value mode cpsr | exp_value exp_wr exp_restore exp_cw exp_cpsr
// all hex; exp_cw 0 marks no CPSR write; a line of ffffffff ends the list
0 4 1 1 2 003 00000005 00000007 0 0000001f 0000000c 1 0 1 0000001f // add
0 4 1 4 5 006 ffffffff 00000001 3 900000d3 00000000 1 0 1 600000d3 // add carry, zero
0 4 1 1 f 002 7fffffff 00000001 2 20000010 80000000 1 1 1 90000010 // add overflow, restore
1 4 0 3 f 0ff 00000100 00000000 7 00000000 000001ff 1 0 0 00000000 // s clear
0 4 1 2 f 005 80000000 80000000 1 0000001f 00000000 1 0 1 7000001f // mode 1
0 a 0 1 0 002 00000010 00000010 0 00000010 00000000 0 0 1 60000010 // cmp equal
0 a 1 6 0 007 00000003 00000005 3 f0000013 00000000 0 0 1 80000013 // cmp borrow
1 a 0 9 0 001 80000000 00000000 0 00000000 00000000 0 0 1 30000000 // cmp overflow
1 0 0 4 1 0f0 12345678 00000000 0 00000000 00000070 1 0 0 00000000
1 d 0 5 7 abc 00000000 00000000 0 00000000 00000abc 1 0 0 00000000
0 0 1 2 3 00a f0000000 80000001 0 3000001f 80000000 1 0 1 b000001f // and keeps c, v
1 d 1 8 f 000 00000000 00000000 0 a0000010 00000000 1 0 1 60000010 // mode 0
0 d 1 3 f 5ac 00000000 80000000 2 50000000 80000000 1 1 1 90000000 // shift bits ignored
1 4 1 1 e 010 00000020 00000000 3 000000d3 00000030 1 0 1 000000d3 // rd 14
0 1 1 1 2 003 00000005 00000007 0 00000000 00000000 0 0 0 00000000 // unknown opcode
ffffffff

/* sim.f */
+incdir+src
src/alu_isa_pkg.sv
src/alu_psr_pkg.sv
src/alu_ifs.sv
src/alu_datapath.sv
src/operand_fetch.sv
src/psr_unit.sv
src/alu_sequencer.sv
src/alu_top.sv
bench/alu_chk.sv
bench/alu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module alu_tb -o alu_tb_sim

if ./obj_dir/alu_tb_sim | tee /dev/stderr | grep -qF '** PASS **'; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
